// File: rtl/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// datapath and csr address widths
`define CPU_WIDTH 32
`define CSR_ADDRW 12

// machine-mode csr addresses
`define ADDR_MSTATUS 12'h300
`define ADDR_MTVEC   12'h305
`define ADDR_MEPC    12'h341
`define ADDR_MCAUSE  12'h342

// mstatus bit positions
`define MSTATUS_MIE  3  // global interrupt enable
`define MSTATUS_MPIE 7  // stacked copy of mie

`define MSTATUS_RESET  32'h0000_1800  // mpp = 11, all else zero
`define MCAUSE_ECALL   32'h0000_000b  // ecall from m-mode
`define MCAUSE_IRQ_EXT 32'h8000_000b  // interrupt bit + external irq

`endif

// File: rtl/csr_pkg.sv
`default_nettype none

`include "csr_settings.svh"

package csr_pkg;

  // encodings follow funct3[1:0] of csrrw/csrrs/csrrc
  typedef enum logic [1:0] {
    RW = 2'b01,
    RS = 2'b10,
    RC = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    ECALL = 2'b00,
    IRQ   = 2'b01,  // external interrupt
    MRET  = 2'b10
  } trap_kind_e;

  // csr instruction from decode/execute
  typedef struct packed {
    logic                  valid;    // one-cycle strobe
    csr_op_e               op;
    logic [`CSR_ADDRW-1:0] addr;
    logic [`CPU_WIDTH-1:0] operand;  // rs1 or zimm, already resolved
    logic [`CPU_WIDTH-1:0] pc;       // tag only
  } csr_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`CPU_WIDTH-1:0] rdata;  // value before the write
  } csr_rsp_t;

  // trap or mret event
  typedef struct packed {
    logic                  valid;
    trap_kind_e            kind;
    logic [`CPU_WIDTH-1:0] pc;  // pc of faulting/interrupted instr
  } trap_req_t;

  // instruction-side write out of csr_rmw
  typedef struct packed {
    logic                  valid;
    logic [`CSR_ADDRW-1:0] addr;
    logic [`CPU_WIDTH-1:0] data;
  } csr_wr_t;

  // trap-side update out of trap_ctrl
  typedef struct packed {
    logic                  valid;   // accepted event only
    trap_kind_e            kind;    // mret leaves mepc/mcause alone
    logic [`CPU_WIDTH-1:0] mepc;
    logic [`CPU_WIDTH-1:0] mcause;
    logic [`CPU_WIDTH-1:0] mstatus;
    logic [`CPU_WIDTH-1:0] target;  // redirect pc
  } trap_wr_t;

  typedef struct packed {
    logic                  valid;
    logic [`CPU_WIDTH-1:0] pc;
  } redirect_t;

endpackage

`default_nettype wire

// File: rtl/csr_rmw.sv
`default_nettype none

`include "csr_settings.svh"

// read-modify-write for csrrw/csrrs/csrrc
// purely combinational, old value comes back from csrfile
module csr_rmw (
  input  wire csr_pkg::csr_req_t      i_req,
  input  wire logic [`CPU_WIDTH-1:0]  i_cur,  // current value at i_req.addr
  output csr_pkg::csr_wr_t            o_wr
);

  import csr_pkg::*;

  logic [`CPU_WIDTH-1:0] new_val;  // value after the op
  logic                  is_write;  // op actually modifies the csr

  // new value from op
  always_comb begin
    case (i_req.op)
      RW:      new_val = i_req.operand;
      RS:      new_val = i_cur | i_req.operand;   // set bits
      RC:      new_val = i_cur & ~i_req.operand;  // clear bits
      default: new_val = i_cur;                   // reserved encoding
    endcase
  end

  // set/clear with zero operand is a pure read
  always_comb begin
    case (i_req.op)
      RW:      is_write = 1'b1;
      RS, RC:  is_write = |i_req.operand;
      default: is_write = 1'b0;  // nothing to do
    endcase
  end

  // strobe only when the request is live
  assign o_wr.valid = i_req.valid & is_write;
  assign o_wr.addr  = i_req.addr;  // decoded later in csrfile
  assign o_wr.data  = new_val;

endmodule

`default_nettype wire

// File: rtl/trap_ctrl.sv
`default_nettype none

`include "csr_settings.svh"

// trap entry and mret
// ecall and irq stack mie into mpie and jump to mtvec
// mret unstacks and jumps back to mepc
module trap_ctrl (
  input  wire csr_pkg::trap_req_t     i_trap,
  input  wire logic [`CPU_WIDTH-1:0]  i_mstatus,
  input  wire logic [`CPU_WIDTH-1:0]  i_mtvec,
  input  wire logic [`CPU_WIDTH-1:0]  i_mepc,
  output csr_pkg::trap_wr_t           o_twr
);

  import csr_pkg::*;

  logic mie;   // current global enable
  logic mpie;  // current stacked enable
  logic is_irq;

  assign mie    = i_mstatus[`MSTATUS_MIE];
  assign mpie   = i_mstatus[`MSTATUS_MPIE];
  assign is_irq = (i_trap.kind == IRQ);

  always_comb begin
    // defaults for an event that is not accepted
    o_twr         = '0;
    o_twr.kind    = i_trap.kind;  // tells csrfile which fields land
    o_twr.mepc    = i_trap.pc;
    o_twr.mstatus = i_mstatus;    // mpp and others carried through

    case (i_trap.kind)
      ECALL, IRQ: begin
        // irq masked by mie while ecall is always taken
        o_twr.valid  = i_trap.valid & (~is_irq | mie);
        o_twr.mcause = is_irq ? `MCAUSE_IRQ_EXT : `MCAUSE_ECALL;
        o_twr.mstatus[`MSTATUS_MPIE] = mie;  // stack
        o_twr.mstatus[`MSTATUS_MIE]  = 1'b0;
        o_twr.target = i_mtvec;  // direct mode only
      end
      MRET: begin
        o_twr.valid = i_trap.valid;
        o_twr.mstatus[`MSTATUS_MIE]  = mpie;  // unstack
        o_twr.mstatus[`MSTATUS_MPIE] = 1'b1;
        o_twr.target = i_mepc;  // return to trapped pc
      end
      default: begin
        o_twr.valid = 1'b0;  // unused kind is dropped
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/csrfile.sv
`default_nettype none

`include "csr_settings.svh"

// machine csr storage
// one read port on the request addr, instruction and trap writes merged
// trap fields win, response and redirect registered for one cycle
module csrfile (
  input  wire logic                   i_clk,
  input  wire logic                   i_reset,

  // instruction read side
  input  wire logic [`CSR_ADDRW-1:0]  i_raddr,
  input  wire logic                   i_req_valid,
  output logic [`CPU_WIDTH-1:0]       o_cur,      // to csr_rmw

  // state for trap_ctrl
  output logic [`CPU_WIDTH-1:0]       o_mstatus,
  output logic [`CPU_WIDTH-1:0]       o_mtvec,
  output logic [`CPU_WIDTH-1:0]       o_mepc,

  // write sets
  input  wire csr_pkg::csr_wr_t       i_wr,
  input  wire csr_pkg::trap_wr_t      i_twr,

  output csr_pkg::csr_rsp_t           o_csr_rsp,
  output csr_pkg::redirect_t          o_redirect
);

  import csr_pkg::*;

  // only mie and mpie are writable in mstatus
  localparam logic [`CPU_WIDTH-1:0] MSTATUS_WMASK =
    (`CPU_WIDTH'(1) << `MSTATUS_MIE) | (`CPU_WIDTH'(1) << `MSTATUS_MPIE);

  logic [`CPU_WIDTH-1:0] mstatus;
  logic [`CPU_WIDTH-1:0] mtvec;   // trap base, low bits always 0
  logic [`CPU_WIDTH-1:0] mepc;
  logic [`CPU_WIDTH-1:0] mcause;

  logic wr_mstatus, wr_mtvec, wr_mepc, wr_mcause;  // instr addr decode
  logic trap_ctx;  // ecall/irq entry, writes mepc and mcause

  logic [`CPU_WIDTH-1:0] mstatus_d;
  logic [`CPU_WIDTH-1:0] mtvec_d;
  logic [`CPU_WIDTH-1:0] mepc_d;
  logic [`CPU_WIDTH-1:0] mcause_d;

  // read mux, unknown addr reads zero
  always_comb begin
    case (i_raddr)
      `ADDR_MSTATUS: o_cur = mstatus;
      `ADDR_MTVEC:   o_cur = mtvec;
      `ADDR_MEPC:    o_cur = mepc;
      `ADDR_MCAUSE:  o_cur = mcause;
      default:       o_cur = '0;
    endcase
  end

  assign o_mstatus = mstatus;
  assign o_mtvec   = mtvec;
  assign o_mepc    = mepc;

  assign wr_mstatus = i_wr.valid && (i_wr.addr == `ADDR_MSTATUS);
  assign wr_mtvec   = i_wr.valid && (i_wr.addr == `ADDR_MTVEC);
  assign wr_mepc    = i_wr.valid && (i_wr.addr == `ADDR_MEPC);
  assign wr_mcause  = i_wr.valid && (i_wr.addr == `ADDR_MCAUSE);
  assign trap_ctx   = i_twr.valid && (i_twr.kind != MRET);

  // merge with trap priority
  always_comb begin
    mstatus_d = i_twr.valid ? i_twr.mstatus : i_wr.data;
    mstatus_d = (mstatus_d & MSTATUS_WMASK) | `MSTATUS_RESET;  // mpp pinned to 11
    mtvec_d   = {i_wr.data[`CPU_WIDTH-1:2], 2'b00};  // instruction only
    mepc_d    = trap_ctx ? i_twr.mepc : i_wr.data;
    mcause_d  = trap_ctx ? i_twr.mcause : i_wr.data;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mstatus <= `MSTATUS_RESET;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (i_twr.valid || wr_mstatus) mstatus <= mstatus_d;
      if (wr_mtvec)                  mtvec   <= mtvec_d;
      if (trap_ctx || wr_mepc)       mepc    <= mepc_d;
      if (trap_ctx || wr_mcause)     mcause  <= mcause_d;
    end
  end

  // response carries the value from before this edge
  // redirect target was built from pre-edge mtvec/mepc
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_csr_rsp  <= '0;
      o_redirect <= '0;
    end else begin
      o_csr_rsp.valid  <= i_req_valid;
      o_csr_rsp.rdata  <= o_cur;
      o_redirect.valid <= i_twr.valid;  // single pulse, no hold
      o_redirect.pc    <= i_twr.target;
    end
  end

endmodule

`default_nettype wire

// File: rtl/csr_unit.sv
`default_nettype none

`include "csr_settings.svh"

// m-mode csr subsystem top
// rmw and trap paths run in parallel, csrfile owns the state
module csr_unit (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset,
  input  wire csr_pkg::csr_req_t    i_csr_req,
  input  wire csr_pkg::trap_req_t   i_trap,
  output csr_pkg::csr_rsp_t         o_csr_rsp,
  output csr_pkg::redirect_t        o_redirect
);

  import csr_pkg::*;

  logic [`CPU_WIDTH-1:0] cur;      // csr value at request addr
  logic [`CPU_WIDTH-1:0] mstatus;
  logic [`CPU_WIDTH-1:0] mtvec;
  logic [`CPU_WIDTH-1:0] mepc;
  csr_wr_t               wr;       // instruction write
  trap_wr_t              twr;      // trap update

  csr_rmw u_csr_rmw (
    .i_req (i_csr_req),
    .i_cur (cur),
    .o_wr  (wr)
  );

  trap_ctrl u_trap_ctrl (
    .i_trap    (i_trap),
    .i_mstatus (mstatus),
    .i_mtvec   (mtvec),
    .i_mepc    (mepc),
    .o_twr     (twr)
  );

  csrfile u_csrfile (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_raddr     (i_csr_req.addr),
    .i_req_valid (i_csr_req.valid),
    .o_cur       (cur),
    .o_mstatus   (mstatus),
    .o_mtvec     (mtvec),
    .o_mepc      (mepc),
    .i_wr        (wr),
    .i_twr       (twr),
    .o_csr_rsp   (o_csr_rsp),
    .o_redirect  (o_redirect)
  );

endmodule

`default_nettype wire

// File: testbench/tb_csr_unit.sv
`default_nettype none

`include "csr_settings.svh"

module tb_csr_unit;
  timeunit 1ns;
  timeprecision 100ps;

  import csr_pkg::*;

  localparam int NUM_CYCLES    = 3000;
  localparam int RESET_TIMEOUT = 10;  // cycles allowed for idle outputs

  logic      i_clk;
  logic      i_reset;
  csr_req_t  req;    // driven on the falling edge
  trap_req_t trap;
  csr_rsp_t  rsp;
  redirect_t redir;

  logic [31:0] seed;  // xorshift state

  // model csrs updated when a stimulus is driven
  logic [31:0] m_mstatus;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;

  // outputs expected after the next rising edge
  logic        exp_rsp_valid;
  logic [31:0] exp_rdata;
  logic        exp_redir_valid;
  logic [31:0] exp_redir_pc;
  logic [31:0] exp_tag;  // pc tag of the request in flight

  csr_unit u_csr_unit (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_csr_req  (req),
    .i_trap     (trap),
    .o_csr_rsp  (rsp),
    .o_redirect (redir)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;  // 20 ns period
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic roll(output logic [31:0] r);
    seed = xorshift32(seed);
    r    = seed;
  endtask

  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] model_read(input logic [`CSR_ADDRW-1:0] addr);
    case (addr)
      `ADDR_MSTATUS: return m_mstatus;
      `ADDR_MTVEC:   return m_mtvec;
      `ADDR_MEPC:    return m_mepc;
      `ADDR_MCAUSE:  return m_mcause;
      default:       return 32'h0;  // unmapped
    endcase
  endfunction

  // predicts the outputs for req/trap and advances the model state
  task automatic model_step();
    logic [31:0] cur;
    logic [31:0] data;
    logic        wr;
    logic        mie;
    logic        mpie;
    logic        take;
    logic [31:0] n_mstatus;
    logic [31:0] n_mtvec;
    logic [31:0] n_mepc;
    logic [31:0] n_mcause;

    cur       = model_read(req.addr);
    mie       = m_mstatus[`MSTATUS_MIE];
    mpie      = m_mstatus[`MSTATUS_MPIE];
    n_mstatus = m_mstatus;
    n_mtvec   = m_mtvec;
    n_mepc    = m_mepc;
    n_mcause  = m_mcause;

    case (req.op)
      RS:      data = cur | req.operand;
      RC:      data = cur & ~req.operand;
      default: data = req.operand;  // csrrw
    endcase
    wr = req.valid && (req.op == RW || req.operand != 32'h0);  // set/clear of 0 is a read
    if (wr) begin
      case (req.addr)
        `ADDR_MSTATUS: begin
          n_mstatus = `MSTATUS_RESET;  // mpp stays 11
          n_mstatus[`MSTATUS_MIE]  = data[`MSTATUS_MIE];
          n_mstatus[`MSTATUS_MPIE] = data[`MSTATUS_MPIE];
        end
        `ADDR_MTVEC:  n_mtvec  = data & 32'hffff_fffc;  // direct mode
        `ADDR_MEPC:   n_mepc   = data;
        `ADDR_MCAUSE: n_mcause = data;
        default: ;  // write dropped
      endcase
    end

    // trap side overrides the instruction on shared fields
    take = trap.valid && (trap.kind != IRQ || mie);
    if (take) begin
      n_mstatus = `MSTATUS_RESET;
      if (trap.kind == MRET) begin
        n_mstatus[`MSTATUS_MIE]  = mpie;
        n_mstatus[`MSTATUS_MPIE] = 1'b1;
      end else begin
        n_mstatus[`MSTATUS_MPIE] = mie;
        n_mstatus[`MSTATUS_MIE]  = 1'b0;
        n_mepc   = trap.pc;
        n_mcause = (trap.kind == IRQ) ? `MCAUSE_IRQ_EXT : `MCAUSE_ECALL;
      end
    end

    exp_rsp_valid   = req.valid;
    exp_rdata       = cur;  // old value
    exp_tag         = req.pc;
    exp_redir_valid = take;
    exp_redir_pc    = (trap.kind == MRET) ? m_mepc : m_mtvec;  // pre-edge values

    m_mstatus = n_mstatus;
    m_mtvec   = n_mtvec;
    m_mepc    = n_mepc;
    m_mcause  = n_mcause;
  endtask

  task automatic check_outputs();
    check("o_csr_rsp.valid", 32'(rsp.valid), 32'(exp_rsp_valid));
    if (exp_rsp_valid) begin
      check($sformatf("o_csr_rsp.rdata (request pc %h)", exp_tag), rsp.rdata, exp_rdata);
    end
    check("o_redirect.valid", 32'(redir.valid), 32'(exp_redir_valid));
    if (exp_redir_valid) check("o_redirect.pc", redir.pc, exp_redir_pc);
  endtask

  // outputs of the last edge are stable at the falling edge
  task automatic step(input csr_req_t nreq, input trap_req_t ntrap);
    @(negedge i_clk);
    check_outputs();
    req  = nreq;
    trap = ntrap;
    model_step();
  endtask

  task automatic random_req(output csr_req_t r);
    logic [31:0] x;
    r = '0;
    roll(x);
    r.valid = x[4];  // about half the cycles
    roll(x);
    case (x % 32'd3)
      32'd0:   r.op = RW;
      32'd1:   r.op = RS;
      default: r.op = RC;
    endcase
    roll(x);
    case (x[2:0])
      3'd0, 3'd1: r.addr = `ADDR_MSTATUS;
      3'd2, 3'd3: r.addr = `ADDR_MTVEC;
      3'd4:       r.addr = `ADDR_MEPC;
      3'd5:       r.addr = `ADDR_MCAUSE;
      default:    r.addr = x[19:8];  // mostly unmapped
    endcase
    roll(x);
    case (x[1:0])
      2'd0:    r.operand = 32'h0;
      2'd1:    r.operand = 32'h1 << x[12:8];  // single bit often hitting mie/mpie
      default: r.operand = xorshift32(x);
    endcase
    roll(x);
    r.pc = {x[31:2], 2'b00};  // tag only
  endtask

  task automatic random_trap(output trap_req_t t);
    logic [31:0] x;
    t = '0;
    roll(x);
    t.valid = ((x % 32'd5) == 32'd0);  // about 20%
    roll(x);
    case (x % 32'd3)
      32'd0:   t.kind = ECALL;
      32'd1:   t.kind = IRQ;
      default: t.kind = MRET;
    endcase
    roll(x);
    t.pc = {x[31:2], 2'b00};
  endtask

  initial begin
    csr_req_t  nreq;
    trap_req_t ntrap;
    int        wait_cnt;

    seed            = 32'hceec_dbb5;
    i_reset         = 1'b1;
    req             = '0;
    trap            = '0;
    m_mstatus       = `MSTATUS_RESET;
    m_mtvec         = 32'h0;
    m_mepc          = 32'h0;
    m_mcause        = 32'h0;
    exp_rsp_valid   = 1'b0;
    exp_rdata       = 32'h0;
    exp_redir_valid = 1'b0;
    exp_redir_pc    = 32'h0;
    exp_tag         = 32'h0;

    repeat (5) @(negedge i_clk);
    i_reset = 1'b0;

    // both outputs idle after reset
    wait_cnt = 0;
    while (rsp.valid || redir.valid) begin
      if (wait_cnt == RESET_TIMEOUT) begin
        fail_stop("Timeout: outputs still valid after reset was released");
      end else begin
        @(negedge i_clk);
        wait_cnt++;
      end
    end

    // pure reads of each csr right after reset
    nreq       = '0;
    ntrap      = '0;
    nreq.valid = 1'b1;
    nreq.op    = RS;  // zero operand so no write
    nreq.addr  = `ADDR_MSTATUS;
    step(nreq, ntrap);
    nreq.addr  = `ADDR_MTVEC;
    step(nreq, ntrap);
    nreq.addr  = `ADDR_MEPC;
    step(nreq, ntrap);
    nreq.addr  = `ADDR_MCAUSE;
    step(nreq, ntrap);

    for (int n = 0; n < NUM_CYCLES; n++) begin
      random_req(nreq);
      random_trap(ntrap);
      step(nreq, ntrap);
    end

    // drain the last request and trap
    nreq  = '0;
    ntrap = '0;
    step(nreq, ntrap);
    @(negedge i_clk);
    check_outputs();

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_rmw.sv
rtl/trap_ctrl.sv
rtl/csrfile.sv
rtl/csr_unit.sv
testbench/tb_csr_unit.sv

// File: run.sh
#!/usr/bin/env bash
# build the csr testbench with verilator and run it
# exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
  verilator --binary --timing -f files.f --top-module tb_csr_unit -o tb_csr_unit &&
  ./obj_dir/tb_csr_unit ||
  { echo "csr simulation did not pass"; exit 1; }
exit 0
